/* Makefile */
# Verilator build and run for the pipelined cpu

VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = cpu_tb
FLIST     = flist.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = ALL TESTS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

# the log decides pass or fail, not the simulator exit code
run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* dv/cpu_model.svh */
`ifndef CPU_MODEL_SVH
`define CPU_MODEL_SVH

localparam int PROG_LEN = 64;

// instruction kinds of the random program
localparam int K_ADD  = 0;
localparam int K_SUB  = 1;
localparam int K_AND  = 2;
localparam int K_OR   = 3;
localparam int K_XOR  = 4;
localparam int K_SLT  = 5;
localparam int K_ADDI = 6;
localparam int K_LUI  = 7;
localparam int K_LW   = 8;
localparam int K_SW   = 9;
localparam int K_BEQ  = 10;
localparam int K_BNE  = 11;
localparam int K_JAL  = 12;

integer seed = 6;

// program image and the fields it was built from
data_t     prog   [PROG_LEN];
int        p_kind [PROG_LEN];
reg_addr_t p_rd   [PROG_LEN];
reg_addr_t p_rs1  [PROG_LEN];
reg_addr_t p_rs2  [PROG_LEN];
data_t     p_imm  [PROG_LEN];

// expected streams, oldest first
reg_addr_t exp_wb_rd   [$];
data_t     exp_wb_data [$];
data_t     exp_st_addr [$];
data_t     exp_st_data [$];

function automatic int pick(int n);
    return {$random(seed)} % n;
endfunction

// standard RV32I encodings
function automatic data_t encode(int kind, reg_addr_t rd, reg_addr_t rs1, reg_addr_t rs2,
                                 data_t imm);
    case (kind)
        K_ADD:   return {7'h00, rs2, rs1, 3'b000, rd, OP_REG};
        K_SUB:   return {7'h20, rs2, rs1, 3'b000, rd, OP_REG};
        K_AND:   return {7'h00, rs2, rs1, 3'b111, rd, OP_REG};
        K_OR:    return {7'h00, rs2, rs1, 3'b110, rd, OP_REG};
        K_XOR:   return {7'h00, rs2, rs1, 3'b100, rd, OP_REG};
        K_SLT:   return {7'h00, rs2, rs1, 3'b010, rd, OP_REG};
        K_ADDI:  return {imm[11:0], rs1, 3'b000, rd, OP_IMM};
        K_LUI:   return {imm[31:12], rd, OP_LUI};
        K_LW:    return {imm[11:0], 5'd0, 3'b010, rd, OP_LOAD};
        K_SW:    return {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], OP_STORE};
        K_BEQ:   return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], OP_BRANCH};
        K_BNE:   return {imm[12], imm[10:5], rs2, rs1, 3'b001, imm[4:1], imm[11], OP_BRANCH};
        default: return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
    endcase
endfunction

task automatic gen_program();
    int        kind;
    int        k;
    int        w;
    reg_addr_t rd;
    reg_addr_t rs1;
    reg_addr_t rs2;
    data_t     imm;
    for (int i = 0; i < PROG_LEN - 1; i++)
    begin
        kind = pick(13);
        k    = 2 + pick(3);
        w    = pick(16);
        rd   = reg_addr_t'(1 + pick(7));
        rs1  = reg_addr_t'(pick(8));
        rs2  = reg_addr_t'(pick(8));
        imm  = data_t'($random(seed));
        // control flow has to land at or before the final loop
        if (kind >= K_BEQ && i + k > PROG_LEN - 1)
        begin
            kind = K_ADDI;
        end
        case (kind)
            K_ADDI:              imm = {{20{imm[11]}}, imm[11:0]};
            K_LUI:               imm = {imm[31:12], 12'b0};
            K_LW, K_SW:          imm = data_t'(w * 4);
            K_BEQ, K_BNE, K_JAL: imm = data_t'(k * 4);
            default:             imm = '0;
        endcase
        if (kind == K_LW || kind == K_SW)
        begin
            rs1 = '0;
        end
        // equal operands make taken branches common
        if ((kind == K_BEQ || kind == K_BNE) && pick(2) == 0)
        begin
            rs2 = rs1;
        end
        p_kind[i] = kind;
        p_rd[i]   = rd;
        p_rs1[i]  = rs1;
        p_rs2[i]  = rs2;
        p_imm[i]  = imm;
        prog[i]   = encode(kind, rd, rs1, rs2, imm);
    end
    // jal x0, 0 spins forever
    p_kind[PROG_LEN-1] = K_JAL;
    p_rd[PROG_LEN-1]   = '0;
    p_rs1[PROG_LEN-1]  = '0;
    p_rs2[PROG_LEN-1]  = '0;
    p_imm[PROG_LEN-1]  = '0;
    prog[PROG_LEN-1]   = encode(K_JAL, '0, '0, '0, '0);
endtask

// architectural run up to the final loop
task automatic run_model();
    data_t regs [32];
    data_t dmem [16];
    data_t a;
    data_t b;
    data_t res;
    int    pc;
    int    next;
    logic  wr;
    for (int i = 0; i < 32; i++)
    begin
        regs[i] = '0;
    end
    for (int i = 0; i < 16; i++)
    begin
        dmem[i] = '0;
    end
    pc = 0;
    while (pc != PROG_LEN - 1)
    begin
        a    = regs[p_rs1[pc]];
        b    = regs[p_rs2[pc]];
        res  = '0;
        next = pc + 1;
        wr   = 1'b1;
        case (p_kind[pc])
            K_ADD:  res = a + b;
            K_SUB:  res = a - b;
            K_AND:  res = a & b;
            K_OR:   res = a | b;
            K_XOR:  res = a ^ b;
            K_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            K_ADDI: res = a + p_imm[pc];
            K_LUI:  res = p_imm[pc];
            K_LW:   res = dmem[p_imm[pc][5:2]];
            K_SW:
            begin
                wr = 1'b0;
                dmem[p_imm[pc][5:2]] = b;
                exp_st_addr.push_back(p_imm[pc] >> 2);
                exp_st_data.push_back(b);
            end
            K_BEQ, K_BNE:
            begin
                wr = 1'b0;
                if ((a == b) == (p_kind[pc] == K_BEQ))
                begin
                    next = pc + int'(p_imm[pc] >> 2);
                end
            end
            default:
            begin
                res  = data_t'((pc + 1) * 4);
                next = pc + int'(p_imm[pc] >> 2);
            end
        endcase
        if (wr && p_rd[pc] != '0)
        begin
            regs[p_rd[pc]] = res;
            exp_wb_rd.push_back(p_rd[pc]);
            exp_wb_data.push_back(res);
        end
        pc = next;
    end
endtask

`endif

/* dv/cpu_tb.sv */
`default_nettype none

module cpu_tb
    import defs::*;
();

    localparam int TIMEOUT_CYCLES = 2000;
    localparam int DRAIN_CYCLES   = 30;

    logic      clk;
    logic      arst_n;
    logic      imem_we;
    data_t     imem_addr;
    data_t     imem_wdata;
    logic      wb_valid;
    reg_addr_t wb_rd;
    data_t     wb_data;
    logic      dmem_we;
    data_t     dmem_addr;
    data_t     dmem_wdata;

    int wb_errors    = 0;
    int st_errors    = 0;
    int other_errors = 0;

    `include "cpu_model.svh"

    cpu #(
        .IMEM_WORDS(256),
        .DMEM_WORDS(64)
    ) cpu_inst (
        .clk(clk),
        .arst_n_i(arst_n),
        .imem_we_i(imem_we),
        .imem_addr_i(imem_addr),
        .imem_wdata_i(imem_wdata),
        .wb_valid_o(wb_valid),
        .wb_rd_o(wb_rd),
        .wb_data_o(wb_data),
        .dmem_we_o(dmem_we),
        .dmem_addr_o(dmem_addr),
        .dmem_wdata_o(dmem_wdata)
    );

    always #4 clk = ~clk;

    task automatic check_wb(input reg_addr_t got_rd, input data_t got_data);
        reg_addr_t exp_rd;
        data_t     exp_data;
        if (exp_wb_rd.size() == 0)
        begin
            $display("unexpected register write at %0t: x%0d = %08h after the last expected one",
                     $time, got_rd, got_data);
            wb_errors++;
        end
        else
        begin
            exp_rd   = exp_wb_rd.pop_front();
            exp_data = exp_wb_data.pop_front();
            if (got_rd !== exp_rd)
            begin
                $display("error at %0t: wb_rd_o is %0d, expected %0d", $time, got_rd, exp_rd);
                wb_errors++;
            end
            if (got_data !== exp_data)
            begin
                $display("error at %0t: wb_data_o is %08h, expected %08h",
                         $time, got_data, exp_data);
                wb_errors++;
            end
        end
    endtask

    task automatic check_store(input data_t got_addr, input data_t got_data);
        data_t exp_addr;
        data_t exp_data;
        if (exp_st_addr.size() == 0)
        begin
            $display("unexpected store at %0t: word %0d = %08h after the last expected one",
                     $time, got_addr, got_data);
            st_errors++;
        end
        else
        begin
            exp_addr = exp_st_addr.pop_front();
            exp_data = exp_st_data.pop_front();
            if (got_addr !== exp_addr)
            begin
                $display("error at %0t: dmem_addr_o is %0d, expected %0d",
                         $time, got_addr, exp_addr);
                st_errors++;
            end
            if (got_data !== exp_data)
            begin
                $display("error at %0t: dmem_wdata_o is %08h, expected %08h",
                         $time, got_data, exp_data);
                st_errors++;
            end
        end
    endtask

    // outputs are settled by the falling edge
    always @(negedge clk)
    begin
        if (arst_n)
        begin
            if (wb_valid)
            begin
                check_wb(wb_rd, wb_data);
            end
            if (dmem_we)
            begin
                check_store(dmem_addr, dmem_wdata);
            end
        end
    end

    initial
    begin
        int cycles;
        clk        = 1'b0;
        arst_n     = 1'b0;
        imem_we    = 1'b0;
        imem_addr  = '0;
        imem_wdata = '0;

        gen_program();
        run_model();
        $display("program of %0d words, expecting %0d register writes and %0d stores",
                 PROG_LEN, exp_wb_rd.size(), exp_st_addr.size());

        // reset stays low through the load and two more cycles
        for (int i = 0; i < PROG_LEN; i++)
        begin
            @(posedge clk);
            imem_we    <= 1'b1;
            imem_addr  <= data_t'(i);
            imem_wdata <= prog[i];
        end
        @(posedge clk);
        imem_we <= 1'b0;
        repeat (2) @(posedge clk);
        arst_n <= 1'b1;

        cycles = 0;
        while ((exp_wb_rd.size() != 0 || exp_st_addr.size() != 0) && cycles < TIMEOUT_CYCLES)
        begin
            @(posedge clk);
            cycles++;
        end
        if (exp_wb_rd.size() != 0 || exp_st_addr.size() != 0)
        begin
            $display("timeout after %0d cycles: %0d register writes and %0d stores never appeared",
                     cycles, exp_wb_rd.size(), exp_st_addr.size());
            other_errors++;
        end

        // the final loop must stay quiet
        cycles = 0;
        while (cycles < DRAIN_CYCLES)
        begin
            @(posedge clk);
            cycles++;
        end

        $display("write errors: %0d, store errors: %0d, other errors: %0d",
                 wb_errors, st_errors, other_errors);
        if (wb_errors == 0 && st_errors == 0 && other_errors == 0)
        begin
            $display("ALL TESTS PASSED");
        end
        else
        begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
+incdir+dv
verilog/defs.sv
verilog/reg_file.sv
verilog/fetch_stage.sv
verilog/decode_ctrl.sv
verilog/execute_stage.sv
verilog/mem_wb_stage.sv
verilog/hazard_unit.sv
verilog/cpu.sv
dv/cpu_tb.sv

/* verilog/cpu.sv */
`default_nettype none

module cpu
    import defs::*;
#(
    parameter int IMEM_WORDS = 256,
    parameter int DMEM_WORDS = 64
) (
    input  logic      clk,
    input  logic      arst_n_i,
    input  logic      imem_we_i,
    input  data_t     imem_addr_i,
    input  data_t     imem_wdata_i,
    output logic      wb_valid_o,
    output reg_addr_t wb_rd_o,
    output data_t     wb_data_o,
    output logic      dmem_we_o,
    output data_t     dmem_addr_o,
    output data_t     dmem_wdata_o
);

    // hazard control
    logic      stall;
    logic      flush_if_id;
    logic      flush_id_ex;
    fwd_sel_t  fwd1_sel;
    fwd_sel_t  fwd2_sel;

    // IF/ID
    data_t     id_pc;
    data_t     id_instr;

    // decode and register file
    reg_addr_t id_rs1;
    reg_addr_t id_rs2;
    data_t     id_rs1_data;
    data_t     id_rs2_data;

    // ID/EX
    data_t     ex_pc;
    data_t     ex_rs1_data;
    data_t     ex_rs2_data;
    data_t     ex_imm;
    reg_addr_t ex_rs1;
    reg_addr_t ex_rs2;
    reg_addr_t ex_rd;
    alu_op_t   ex_alu_op;
    src2_sel_t ex_src2_sel;
    cmp_op_t   ex_cmp_op;
    logic      ex_branch;
    logic      ex_jump;
    logic      ex_mem_write;
    logic      ex_reg_write;
    wb_sel_t   ex_wb_sel;
    logic      ex_is_load;

    // redirect from EX
    logic      redirect;
    data_t     target;

    // EX/MEM
    data_t     mem_alu;
    data_t     mem_store_data;
    reg_addr_t mem_rd;
    logic      mem_reg_write;
    logic      mem_mem_write;
    wb_sel_t   mem_wb_sel;
    data_t     mem_pc4;
    data_t     mem_fwd;

    // writeback, x0 writes never reach here
    logic      wb_we;

    assign ex_is_load = ex_reg_write && (ex_wb_sel == WB_MEM);
    assign wb_valid_o = wb_we;

    fetch_stage #(
        .IMEM_WORDS(IMEM_WORDS)
    ) fetch_inst (
        .clk(clk),
        .arst_n_i(arst_n_i),
        .stall_i(stall),
        .flush_i(flush_if_id),
        .redirect_i(redirect),
        .target_i(target),
        .imem_we_i(imem_we_i),
        .imem_addr_i(imem_addr_i),
        .imem_wdata_i(imem_wdata_i),
        .pc_o(id_pc),
        .instr_o(id_instr)
    );

    decode_ctrl decode_inst (
        .clk(clk),
        .arst_n_i(arst_n_i),
        .flush_i(flush_id_ex),
        .instr_i(id_instr),
        .pc_i(id_pc),
        .rs1_o(id_rs1),
        .rs2_o(id_rs2),
        .rs1_data_i(id_rs1_data),
        .rs2_data_i(id_rs2_data),
        .ex_pc_o(ex_pc),
        .ex_rs1_data_o(ex_rs1_data),
        .ex_rs2_data_o(ex_rs2_data),
        .ex_imm_o(ex_imm),
        .ex_rs1_o(ex_rs1),
        .ex_rs2_o(ex_rs2),
        .ex_rd_o(ex_rd),
        .ex_alu_op_o(ex_alu_op),
        .ex_src2_sel_o(ex_src2_sel),
        .ex_cmp_op_o(ex_cmp_op),
        .ex_branch_o(ex_branch),
        .ex_jump_o(ex_jump),
        .ex_mem_write_o(ex_mem_write),
        .ex_reg_write_o(ex_reg_write),
        .ex_wb_sel_o(ex_wb_sel)
    );

    reg_file reg_file_inst (
        .clk(clk),
        .arst_n_i(arst_n_i),
        .rs1_i(id_rs1),
        .rs2_i(id_rs2),
        .rs1_data_o(id_rs1_data),
        .rs2_data_o(id_rs2_data),
        .we_i(wb_we),
        .rd_i(wb_rd_o),
        .rd_data_i(wb_data_o)
    );

    execute_stage execute_inst (
        .clk(clk),
        .arst_n_i(arst_n_i),
        .ex_pc_i(ex_pc),
        .ex_rs1_data_i(ex_rs1_data),
        .ex_rs2_data_i(ex_rs2_data),
        .ex_imm_i(ex_imm),
        .ex_rd_i(ex_rd),
        .ex_alu_op_i(ex_alu_op),
        .ex_src2_sel_i(ex_src2_sel),
        .ex_cmp_op_i(ex_cmp_op),
        .ex_branch_i(ex_branch),
        .ex_jump_i(ex_jump),
        .ex_mem_write_i(ex_mem_write),
        .ex_reg_write_i(ex_reg_write),
        .ex_wb_sel_i(ex_wb_sel),
        .fwd1_sel_i(fwd1_sel),
        .fwd2_sel_i(fwd2_sel),
        .mem_fwd_i(mem_fwd),
        .wb_fwd_i(wb_data_o),
        .redirect_o(redirect),
        .target_o(target),
        .mem_alu_o(mem_alu),
        .mem_store_data_o(mem_store_data),
        .mem_rd_o(mem_rd),
        .mem_reg_write_o(mem_reg_write),
        .mem_mem_write_o(mem_mem_write),
        .mem_wb_sel_o(mem_wb_sel),
        .mem_pc4_o(mem_pc4)
    );

    mem_wb_stage #(
        .DMEM_WORDS(DMEM_WORDS)
    ) mem_wb_inst (
        .clk(clk),
        .arst_n_i(arst_n_i),
        .mem_alu_i(mem_alu),
        .mem_store_data_i(mem_store_data),
        .mem_rd_i(mem_rd),
        .mem_reg_write_i(mem_reg_write),
        .mem_mem_write_i(mem_mem_write),
        .mem_wb_sel_i(mem_wb_sel),
        .mem_pc4_i(mem_pc4),
        .mem_fwd_o(mem_fwd),
        .wb_we_o(wb_we),
        .wb_rd_o(wb_rd_o),
        .wb_data_o(wb_data_o),
        .dmem_we_o(dmem_we_o),
        .dmem_addr_o(dmem_addr_o),
        .dmem_wdata_o(dmem_wdata_o)
    );

    hazard_unit hazard_inst (
        .id_rs1_i(id_rs1),
        .id_rs2_i(id_rs2),
        .ex_rs1_i(ex_rs1),
        .ex_rs2_i(ex_rs2),
        .ex_rd_i(ex_rd),
        .ex_is_load_i(ex_is_load),
        .mem_rd_i(mem_rd),
        .mem_we_i(mem_reg_write),
        .wb_rd_i(wb_rd_o),
        .wb_we_i(wb_we),
        .redirect_i(redirect),
        .stall_o(stall),
        .flush_if_id_o(flush_if_id),
        .flush_id_ex_o(flush_id_ex),
        .fwd1_sel_o(fwd1_sel),
        .fwd2_sel_o(fwd2_sel)
    );

endmodule

`default_nettype wire

/* verilog/decode_ctrl.sv */
`default_nettype none

module decode_ctrl
    import defs::*;
(
    input  logic      clk,
    input  logic      arst_n_i,
    input  logic      flush_i,
    input  data_t     instr_i,
    input  data_t     pc_i,
    output reg_addr_t rs1_o,
    output reg_addr_t rs2_o,
    input  data_t     rs1_data_i,
    input  data_t     rs2_data_i,
    output data_t     ex_pc_o,
    output data_t     ex_rs1_data_o,
    output data_t     ex_rs2_data_o,
    output data_t     ex_imm_o,
    output reg_addr_t ex_rs1_o,
    output reg_addr_t ex_rs2_o,
    output reg_addr_t ex_rd_o,
    output alu_op_t   ex_alu_op_o,
    output src2_sel_t ex_src2_sel_o,
    output cmp_op_t   ex_cmp_op_o,
    output logic      ex_branch_o,
    output logic      ex_jump_o,
    output logic      ex_mem_write_o,
    output logic      ex_reg_write_o,
    output wb_sel_t   ex_wb_sel_o
);

    opcode_t   opcode;
    funct3_t   funct3;
    reg_addr_t rd;
    data_t     imm_i;
    data_t     imm_s;
    data_t     imm_b;
    data_t     imm_u;
    data_t     imm_j;

    data_t     imm;
    alu_op_t   alu_op;
    src2_sel_t src2_sel;
    cmp_op_t   cmp_op;
    logic      branch;
    logic      jump;
    logic      mem_write;
    logic      reg_write;
    wb_sel_t   wb_sel;

    assign opcode = instr_i[6:0];
    assign rd     = instr_i[11:7];
    assign funct3 = instr_i[14:12];
    assign rs1_o  = instr_i[19:15];
    assign rs2_o  = instr_i[24:20];

    // immediates per format
    assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                    instr_i[11:8], 1'b0};
    assign imm_u = {instr_i[31:12], 12'b0};
    assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                    instr_i[30:21], 1'b0};

    always_comb
    begin
        imm       = imm_i;
        alu_op    = ALU_ADD;
        src2_sel  = SRC2_REG;
        cmp_op    = CMP_EQ;
        branch    = 1'b0;
        jump      = 1'b0;
        mem_write = 1'b0;
        reg_write = 1'b0;
        wb_sel    = WB_ALU;
        case (opcode)
            OP_REG:
            begin
                reg_write = 1'b1;
                case (funct3)
                    3'b000:  alu_op = instr_i[30] ? ALU_SUB : ALU_ADD;
                    3'b010:  alu_op = ALU_SLT;
                    3'b100:  alu_op = ALU_XOR;
                    3'b110:  alu_op = ALU_OR;
                    3'b111:  alu_op = ALU_AND;
                    default: reg_write = 1'b0;
                endcase
            end
            OP_IMM:
            begin
                // only addi, the rest of the group is a nop
                src2_sel  = SRC2_IMM;
                reg_write = (funct3 == 3'b000);
            end
            OP_LUI:
            begin
                imm       = imm_u;
                alu_op    = ALU_PASS_B;
                src2_sel  = SRC2_IMM;
                reg_write = 1'b1;
            end
            OP_LOAD:
            begin
                src2_sel  = SRC2_IMM;
                wb_sel    = WB_MEM;
                reg_write = (funct3 == 3'b010);
            end
            OP_STORE:
            begin
                imm       = imm_s;
                src2_sel  = SRC2_IMM;
                mem_write = (funct3 == 3'b010);
            end
            OP_BRANCH:
            begin
                // beq and bne only
                imm    = imm_b;
                branch = (funct3[2:1] == 2'b00);
                cmp_op = funct3[0] ? CMP_NE : CMP_EQ;
            end
            OP_JAL:
            begin
                imm       = imm_j;
                jump      = 1'b1;
                reg_write = 1'b1;
                wb_sel    = WB_PC4;
            end
            default: ;
        endcase
    end

    // ID/EX control, cleared on flush
    always_ff @(posedge clk or negedge arst_n_i)
    begin
        if (!arst_n_i)
        begin
            ex_branch_o    <= 1'b0;
            ex_jump_o      <= 1'b0;
            ex_mem_write_o <= 1'b0;
            ex_reg_write_o <= 1'b0;
        end
        else if (flush_i)
        begin
            ex_branch_o    <= 1'b0;
            ex_jump_o      <= 1'b0;
            ex_mem_write_o <= 1'b0;
            ex_reg_write_o <= 1'b0;
        end
        else
        begin
            ex_branch_o    <= branch;
            ex_jump_o      <= jump;
            ex_mem_write_o <= mem_write;
            // writes to x0 are dropped here
            ex_reg_write_o <= reg_write && (rd != '0);
        end
    end

    // ID/EX data
    always_ff @(posedge clk)
    begin
        ex_pc_o       <= pc_i;
        ex_rs1_data_o <= rs1_data_i;
        ex_rs2_data_o <= rs2_data_i;
        ex_imm_o      <= imm;
        ex_rs1_o      <= rs1_o;
        ex_rs2_o      <= rs2_o;
        ex_rd_o       <= rd;
        ex_alu_op_o   <= alu_op;
        ex_src2_sel_o <= src2_sel;
        ex_cmp_op_o   <= cmp_op;
        ex_wb_sel_o   <= wb_sel;
    end

endmodule

`default_nettype wire

/* verilog/defs.sv */
`default_nettype none

package defs;

    // datapath widths
    typedef logic [31:0] data_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  funct3_t;

    // major opcodes of the supported subset
    localparam opcode_t OP_REG    = 7'b0110011;
    localparam opcode_t OP_IMM    = 7'b0010011;
    localparam opcode_t OP_LUI    = 7'b0110111;
    localparam opcode_t OP_LOAD   = 7'b0000011;
    localparam opcode_t OP_STORE  = 7'b0100011;
    localparam opcode_t OP_BRANCH = 7'b1100011;
    localparam opcode_t OP_JAL    = 7'b1101111;

    // addi x0, x0, 0
    localparam data_t NOP_INSTR = 32'h0000_0013;

    typedef logic [2:0] alu_op_t;
    localparam alu_op_t ALU_ADD    = 3'd0;
    localparam alu_op_t ALU_SUB    = 3'd1;
    localparam alu_op_t ALU_AND    = 3'd2;
    localparam alu_op_t ALU_OR     = 3'd3;
    localparam alu_op_t ALU_XOR    = 3'd4;
    localparam alu_op_t ALU_SLT    = 3'd5;
    localparam alu_op_t ALU_PASS_B = 3'd6;

    typedef logic src2_sel_t;
    localparam src2_sel_t SRC2_REG = 1'b0;
    localparam src2_sel_t SRC2_IMM = 1'b1;

    typedef logic [1:0] wb_sel_t;
    localparam wb_sel_t WB_ALU = 2'd0;
    localparam wb_sel_t WB_MEM = 2'd1;
    localparam wb_sel_t WB_PC4 = 2'd2;

    typedef logic [1:0] fwd_sel_t;
    localparam fwd_sel_t FWD_REG = 2'd0;
    localparam fwd_sel_t FWD_MEM = 2'd1;
    localparam fwd_sel_t FWD_WB  = 2'd2;

    typedef logic cmp_op_t;
    localparam cmp_op_t CMP_EQ = 1'b0;
    localparam cmp_op_t CMP_NE = 1'b1;

endpackage

`default_nettype wire

/* verilog/execute_stage.sv */
`default_nettype none

module execute_stage
    import defs::*;
(
    input  logic      clk,
    input  logic      arst_n_i,
    input  data_t     ex_pc_i,
    input  data_t     ex_rs1_data_i,
    input  data_t     ex_rs2_data_i,
    input  data_t     ex_imm_i,
    input  reg_addr_t ex_rd_i,
    input  alu_op_t   ex_alu_op_i,
    input  src2_sel_t ex_src2_sel_i,
    input  cmp_op_t   ex_cmp_op_i,
    input  logic      ex_branch_i,
    input  logic      ex_jump_i,
    input  logic      ex_mem_write_i,
    input  logic      ex_reg_write_i,
    input  wb_sel_t   ex_wb_sel_i,
    input  fwd_sel_t  fwd1_sel_i,
    input  fwd_sel_t  fwd2_sel_i,
    input  data_t     mem_fwd_i,
    input  data_t     wb_fwd_i,
    output logic      redirect_o,
    output data_t     target_o,
    output data_t     mem_alu_o,
    output data_t     mem_store_data_o,
    output reg_addr_t mem_rd_o,
    output logic      mem_reg_write_o,
    output logic      mem_mem_write_o,
    output wb_sel_t   mem_wb_sel_o,
    output data_t     mem_pc4_o
);

    data_t op1;
    data_t rs2_val;
    data_t op2;
    data_t alu_res;
    logic  taken;

    function automatic data_t fwd_mux(fwd_sel_t sel, data_t reg_val, data_t mem_val,
                                      data_t wb_val);
        case (sel)
            FWD_MEM: return mem_val;
            FWD_WB:  return wb_val;
            default: return reg_val;
        endcase
    endfunction

    assign op1     = fwd_mux(fwd1_sel_i, ex_rs1_data_i, mem_fwd_i, wb_fwd_i);
    assign rs2_val = fwd_mux(fwd2_sel_i, ex_rs2_data_i, mem_fwd_i, wb_fwd_i);
    assign op2     = (ex_src2_sel_i == SRC2_IMM) ? ex_imm_i : rs2_val;

    always_comb
    begin
        case (ex_alu_op_i)
            ALU_SUB:    alu_res = op1 - op2;
            ALU_AND:    alu_res = op1 & op2;
            ALU_OR:     alu_res = op1 | op2;
            ALU_XOR:    alu_res = op1 ^ op2;
            ALU_SLT:    alu_res = {31'b0, $signed(op1) < $signed(op2)};
            ALU_PASS_B: alu_res = op2;
            default:    alu_res = op1 + op2;
        endcase
    end

    // branch compare always uses the register operand
    assign taken      = ex_branch_i && ((op1 == rs2_val) ^ (ex_cmp_op_i == CMP_NE));
    assign redirect_o = taken || ex_jump_i;
    assign target_o   = ex_pc_i + ex_imm_i;

    // EX/MEM control
    always_ff @(posedge clk or negedge arst_n_i)
    begin
        if (!arst_n_i)
        begin
            mem_reg_write_o <= 1'b0;
            mem_mem_write_o <= 1'b0;
        end
        else
        begin
            mem_reg_write_o <= ex_reg_write_i;
            mem_mem_write_o <= ex_mem_write_i;
        end
    end

    // EX/MEM data
    always_ff @(posedge clk)
    begin
        mem_alu_o        <= alu_res;
        mem_store_data_o <= rs2_val;
        mem_rd_o         <= ex_rd_i;
        mem_wb_sel_o     <= ex_wb_sel_i;
        mem_pc4_o        <= ex_pc_i + 32'd4;
    end

endmodule

`default_nettype wire

/* verilog/fetch_stage.sv */
`default_nettype none

module fetch_stage
    import defs::*;
#(
    parameter int IMEM_WORDS = 256
) (
    input  logic  clk,
    input  logic  arst_n_i,
    input  logic  stall_i,
    input  logic  flush_i,
    input  logic  redirect_i,
    input  data_t target_i,
    input  logic  imem_we_i,
    input  data_t imem_addr_i,
    input  data_t imem_wdata_i,
    output data_t pc_o,
    output data_t instr_o
);

    localparam int IAW = $clog2(IMEM_WORDS);

    data_t imem [IMEM_WORDS];
    data_t pc;

    // load port, word addressed
    always_ff @(posedge clk)
    begin
        if (imem_we_i)
        begin
            imem[imem_addr_i[IAW-1:0]] <= imem_wdata_i;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i)
    begin
        if (!arst_n_i)
        begin
            pc <= '0;
        end
        else if (redirect_i)
        begin
            pc <= target_i;
        end
        else if (!stall_i)
        begin
            pc <= pc + 32'd4;
        end
    end

    // IF/ID register, a flush turns the slot into a nop
    always_ff @(posedge clk or negedge arst_n_i)
    begin
        if (!arst_n_i)
        begin
            pc_o    <= '0;
            instr_o <= NOP_INSTR;
        end
        else if (flush_i)
        begin
            instr_o <= NOP_INSTR;
        end
        else if (!stall_i)
        begin
            pc_o    <= pc;
            instr_o <= imem[pc[IAW+1:2]];
        end
    end

    // targets come from the EX adder
    assert property (@(posedge clk) disable iff (!arst_n_i)
        redirect_i |-> target_i[1:0] == 2'b00);

endmodule

`default_nettype wire

/* verilog/hazard_unit.sv */
`default_nettype none

module hazard_unit
    import defs::*;
(
    input  reg_addr_t id_rs1_i,
    input  reg_addr_t id_rs2_i,
    input  reg_addr_t ex_rs1_i,
    input  reg_addr_t ex_rs2_i,
    input  reg_addr_t ex_rd_i,
    input  logic      ex_is_load_i,
    input  reg_addr_t mem_rd_i,
    input  logic      mem_we_i,
    input  reg_addr_t wb_rd_i,
    input  logic      wb_we_i,
    input  logic      redirect_i,
    output logic      stall_o,
    output logic      flush_if_id_o,
    output logic      flush_id_ex_o,
    output fwd_sel_t  fwd1_sel_o,
    output fwd_sel_t  fwd2_sel_o
);

    logic load_use;

    // MEM is the younger producer, so it wins
    function automatic fwd_sel_t fwd_select(reg_addr_t rs);
        if (rs == '0)
        begin
            return FWD_REG;
        end
        if (mem_we_i && mem_rd_i == rs)
        begin
            return FWD_MEM;
        end
        if (wb_we_i && wb_rd_i == rs)
        begin
            return FWD_WB;
        end
        return FWD_REG;
    endfunction

    always_comb
    begin
        fwd1_sel_o = fwd_select(ex_rs1_i);
        fwd2_sel_o = fwd_select(ex_rs2_i);
    end

    assign load_use = ex_is_load_i && ex_rd_i != '0 &&
                      (ex_rd_i == id_rs1_i || ex_rd_i == id_rs2_i);

    // redirect kills the stalled instruction anyway
    assign stall_o       = load_use && !redirect_i;
    assign flush_if_id_o = redirect_i;
    assign flush_id_ex_o = redirect_i || load_use;

endmodule

`default_nettype wire

/* verilog/mem_wb_stage.sv */
`default_nettype none

module mem_wb_stage
    import defs::*;
#(
    parameter int DMEM_WORDS = 64
) (
    input  logic      clk,
    input  logic      arst_n_i,
    input  data_t     mem_alu_i,
    input  data_t     mem_store_data_i,
    input  reg_addr_t mem_rd_i,
    input  logic      mem_reg_write_i,
    input  logic      mem_mem_write_i,
    input  wb_sel_t   mem_wb_sel_i,
    input  data_t     mem_pc4_i,
    output data_t     mem_fwd_o,
    output logic      wb_we_o,
    output reg_addr_t wb_rd_o,
    output data_t     wb_data_o,
    output logic      dmem_we_o,
    output data_t     dmem_addr_o,
    output data_t     dmem_wdata_o
);

    localparam int DAW = $clog2(DMEM_WORDS);

    data_t   dmem [DMEM_WORDS];
    data_t   result_q;
    data_t   load_q;
    wb_sel_t wb_sel_q;

    assign dmem_we_o    = mem_mem_write_i;
    assign dmem_addr_o  = {2'b00, mem_alu_i[31:2]};
    assign dmem_wdata_o = mem_store_data_i;

    // result a younger instruction can take from here
    assign mem_fwd_o = (mem_wb_sel_i == WB_PC4) ? mem_pc4_i : mem_alu_i;

    always_ff @(posedge clk or negedge arst_n_i)
    begin
        if (!arst_n_i)
        begin
            for (int i = 0; i < DMEM_WORDS; i++)
            begin
                dmem[i] <= '0;
            end
        end
        else if (dmem_we_o)
        begin
            dmem[dmem_addr_o[DAW-1:0]] <= mem_store_data_i;
        end
    end

    // MEM/WB register
    always_ff @(posedge clk or negedge arst_n_i)
    begin
        if (!arst_n_i)
        begin
            wb_we_o <= 1'b0;
        end
        else
        begin
            wb_we_o <= mem_reg_write_i;
        end
    end

    always_ff @(posedge clk)
    begin
        wb_rd_o  <= mem_rd_i;
        wb_sel_q <= mem_wb_sel_i;
        result_q <= mem_fwd_o;
        load_q   <= dmem[dmem_addr_o[DAW-1:0]];
    end

    assign wb_data_o = (wb_sel_q == WB_MEM) ? load_q : result_q;

    // address comes from the EX adder
    assert property (@(posedge clk) disable iff (!arst_n_i)
        dmem_we_o |-> dmem_addr_o < DMEM_WORDS);

endmodule

`default_nettype wire

/* verilog/reg_file.sv */
`default_nettype none

module reg_file
    import defs::*;
(
    input  logic      clk,
    input  logic      arst_n_i,
    input  reg_addr_t rs1_i,
    input  reg_addr_t rs2_i,
    output data_t     rs1_data_o,
    output data_t     rs2_data_o,
    input  logic      we_i,
    input  reg_addr_t rd_i,
    input  data_t     rd_data_i
);

    data_t regs [32];

    always_ff @(posedge clk or negedge arst_n_i)
    begin
        if (!arst_n_i)
        begin
            for (int i = 0; i < 32; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (we_i && rd_i != '0)
        begin
            regs[rd_i] <= rd_data_i;
        end
    end

    // same-cycle write shows up on the read ports
    always_comb
    begin
        rs1_data_o = (we_i && rd_i == rs1_i) ? rd_data_i : regs[rs1_i];
        rs2_data_o = (we_i && rd_i == rs2_i) ? rd_data_i : regs[rs2_i];
        if (rs1_i == '0)
        begin
            rs1_data_o = '0;
        end
        if (rs2_i == '0)
        begin
            rs2_data_o = '0;
        end
    end

endmodule

`default_nettype wire
